// File: source/core_pkg.sv
package core_pkg;

    // =========================================================================
    // Sizes
    // =========================================================================

    localparam int num_lanes      = 3;
    localparam int num_read_ports = 2 * num_lanes;
    localparam int num_regs       = 64;
    localparam int word_width     = 32;
    localparam int reg_addr_width = $clog2(num_regs);
    localparam int opcode_width   = 4;
    localparam int imm_width      = 10;

    typedef logic [reg_addr_width-1:0] reg_addr_t;
    typedef logic [word_width-1:0]     word_t;

    // Codes 8 to 15 are not defined and decode as a no-op
    typedef enum logic [opcode_width-1:0] {
        op_add  = 4'd0,
        op_sub  = 4'd1,
        op_and  = 4'd2,
        op_or   = 4'd3,
        op_xor  = 4'd4,
        op_sll  = 4'd5,
        op_srl  = 4'd6,
        op_addi = 4'd7
    } alu_op_t;

    // =========================================================================
    // Instruction and pipeline payloads
    // =========================================================================

    // Raw 32-bit instruction with its fields listed from the top bit down
    typedef struct packed {
        logic [opcode_width-1:0] opcode;
        reg_addr_t               rd;
        reg_addr_t               rs1;
        reg_addr_t               rs2;
        logic [imm_width-1:0]    imm;
    } instr_t;

    // Slot 0 is the oldest instruction
    typedef struct packed {
        logic [num_lanes-1:0] valid;
        instr_t [num_lanes-1:0] slot;
    } bundle_t;

    typedef struct packed {
        logic      valid;
        alu_op_t   op;
        reg_addr_t rd;
        reg_addr_t rs1;
        reg_addr_t rs2;
        word_t     imm;
        logic      use_rs2;
    } uop_t;

    typedef uop_t [num_lanes-1:0] group_t;

    typedef struct packed {
        logic      valid;
        reg_addr_t rd;
        word_t     value;
    } result_t;

    typedef result_t [num_lanes-1:0] result_group_t;

endpackage

// File: source/lane_alu.sv
`timescale 1ns/10ps

module lane_alu (
    input  core_pkg::alu_op_t op,
    input  core_pkg::word_t   a,
    input  core_pkg::word_t   b,
    input  core_pkg::word_t   imm,
    output core_pkg::word_t   value
);
    import core_pkg::*;

    logic [4:0] shamt;

    // Shift amount from the low bits of operand b
    assign shamt = b[4:0];

    always_comb begin
        case (op)
            op_add:  value = a + b;
            op_sub:  value = a - b;
            op_and:  value = a & b;
            op_or:   value = a | b;
            op_xor:  value = a ^ b;
            op_sll:  value = a << shamt;
            op_srl:  value = a >> shamt;
            op_addi: value = a + imm;
            default: value = a + b;
        endcase
    end

endmodule

// File: source/issue_decoder.sv
`timescale 1ns/10ps

module issue_decoder (
    input  logic              clk,
    input  logic              reset,
    input  core_pkg::bundle_t in_bundle,
    input  logic              in_valid,
    output logic              in_ready,
    output core_pkg::group_t  issue_group,
    output logic              issue_valid,
    input  logic              issue_ready
);
    import core_pkg::*;

    bundle_t              held_q;
    logic [num_lanes-1:0] pending_q;
    logic                 run_q;
    logic                 use_held;
    bundle_t              src_bundle;
    logic [num_lanes-1:0] active;
    logic [num_lanes-1:0] issue_mask;
    group_t               slot_uop;

    function automatic uop_t decode_slot(instr_t instr);
        uop_t u;
        u.valid = 1'b0;
        u.rs1   = instr.rs1;
        u.rs2   = instr.rs2;
        u.imm   = {{(word_width-imm_width){instr.imm[imm_width-1]}}, instr.imm};
        // Top opcode bit set means an undefined code, turned into a no-op
        if (instr.opcode[opcode_width-1]) begin
            u.op = op_add;
            u.rd = '0;
        end else begin
            u.op = alu_op_t'(instr.opcode);
            u.rd = instr.rd;
        end
        u.use_rs2 = (u.op != op_addi);
        return u;
    endfunction

    function automatic logic rd_clash(group_t g);
        logic clash;
        clash = 1'b0;
        for (int i = 0; i < num_lanes; i++) begin
            for (int j = 0; j < i; j++) begin
                if (g[i].valid && g[j].valid && g[j].rd != '0 && g[i].rd == g[j].rd) begin
                    clash = 1'b1;
                end
            end
        end
        return clash;
    endfunction

    // Leftover slots of a split bundle take priority over the input port
    assign use_held   = |pending_q;
    assign src_bundle = use_held ? held_q : in_bundle;
    assign active     = use_held ? pending_q : ((in_valid && run_q) ? in_bundle.valid : '0);

    // =========================================================================
    // Group formation
    // =========================================================================

    always_comb begin
        logic stop;
        logic hazard;
        stop       = 1'b0;
        issue_mask = '0;
        for (int i = 0; i < num_lanes; i++) begin
            slot_uop[i] = decode_slot(src_bundle.slot[i]);
            hazard      = 1'b0;
            for (int j = 0; j < i; j++) begin
                if (issue_mask[j] && slot_uop[j].rd != '0 &&
                    (slot_uop[i].rs1 == slot_uop[j].rd ||
                     (slot_uop[i].use_rs2 && slot_uop[i].rs2 == slot_uop[j].rd) ||
                     slot_uop[i].rd == slot_uop[j].rd)) begin
                    hazard = 1'b1;
                end
            end
            // First hazard closes the group, later slots wait
            if (active[i] && !stop) begin
                if (hazard) begin
                    stop = 1'b1;
                end else begin
                    issue_mask[i] = 1'b1;
                end
            end
        end
        issue_group = slot_uop;
        for (int i = 0; i < num_lanes; i++) begin
            issue_group[i].valid = issue_mask[i];
        end
    end

    assign issue_valid = |issue_mask;
    assign in_ready    = run_q && !use_held && issue_ready;

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            run_q     <= 1'b0;
            pending_q <= '0;
            held_q    <= '0;
        end else begin
            run_q <= 1'b1;
            if (issue_valid && issue_ready) begin
                pending_q <= active & ~issue_mask;
                if (!use_held) begin
                    held_q <= in_bundle;
                end
            end
        end
    end

    no_rd_clash: assert property (@(posedge clk) disable iff (!reset)
        issue_valid |-> !rd_clash(issue_group));

endmodule

// File: source/multi_port_register_file.sv
`timescale 1ns/10ps

module multi_port_register_file (
    input  logic                                                clk,
    input  logic                                                reset,
    input  core_pkg::reg_addr_t [core_pkg::num_read_ports-1:0] read_addr,
    output core_pkg::word_t     [core_pkg::num_read_ports-1:0] read_data,
    input  core_pkg::result_t   [core_pkg::num_lanes-1:0]      commits
);
    import core_pkg::*;

    word_t regs [num_regs];

    function automatic logic commit_clash(result_t [num_lanes-1:0] c);
        logic clash;
        clash = 1'b0;
        for (int i = 0; i < num_lanes; i++) begin
            for (int j = 0; j < i; j++) begin
                if (c[i].valid && c[j].valid && c[j].rd != '0 && c[i].rd == c[j].rd) begin
                    clash = 1'b1;
                end
            end
        end
        return clash;
    endfunction

    // =========================================================================
    // Write ports
    // =========================================================================

    // x0 is never written, so it keeps its reset value
    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            for (int r = 0; r < num_regs; r++) begin
                regs[r] <= '0;
            end
        end else begin
            for (int c = 0; c < num_lanes; c++) begin
                if (commits[c].valid && commits[c].rd != '0) begin
                    regs[commits[c].rd] <= commits[c].value;
                end
            end
        end
    end

    // =========================================================================
    // Read ports with commit forwarding
    // =========================================================================

    // Later commit lanes override earlier ones
    always_comb begin
        for (int p = 0; p < num_read_ports; p++) begin
            read_data[p] = regs[read_addr[p]];
            for (int c = 0; c < num_lanes; c++) begin
                if (commits[c].valid && commits[c].rd != '0 &&
                    commits[c].rd == read_addr[p]) begin
                    read_data[p] = commits[c].value;
                end
            end
        end
    end

    distinct_commits: assert property (@(posedge clk) disable iff (!reset)
        !commit_clash(commits));

endmodule

// File: source/execute_stage.sv
`timescale 1ns/10ps

module execute_stage (
    input  logic                                                clk,
    input  logic                                                reset,
    input  core_pkg::group_t                                    issue_group,
    input  logic                                                issue_valid,
    output logic                                                issue_ready,
    output core_pkg::reg_addr_t [core_pkg::num_read_ports-1:0] read_addr,
    input  core_pkg::word_t     [core_pkg::num_read_ports-1:0] read_data,
    output core_pkg::result_group_t                             exec_results,
    output logic                                                exec_valid,
    input  logic                                                exec_ready
);
    import core_pkg::*;

    group_t group_q;
    logic   full_q;
    word_t  alu_value [num_lanes];

    // Accept when empty or when the held group leaves this cycle
    assign issue_ready = !full_q || exec_ready;
    assign exec_valid  = full_q;

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            full_q  <= 1'b0;
            group_q <= '0;
        end else if (issue_ready) begin
            full_q <= issue_valid;
            if (issue_valid) begin
                group_q <= issue_group;
            end
        end
    end

    // =========================================================================
    // Operand fetch and lane ALUs
    // =========================================================================

    for (genvar l = 0; l < num_lanes; l++) begin : g_lane
        // Port 2l carries operand a, port 2l+1 operand b
        assign read_addr[2*l]   = group_q[l].rs1;
        assign read_addr[2*l+1] = group_q[l].rs2;

        lane_alu i_lane_alu (
            .op    (group_q[l].op),
            .a     (read_data[2*l]),
            .b     (read_data[2*l+1]),
            .imm   (group_q[l].imm),
            .value (alu_value[l])
        );

        assign exec_results[l].valid = group_q[l].valid;
        assign exec_results[l].rd    = group_q[l].rd;
        assign exec_results[l].value = alu_value[l];
    end

endmodule

// File: source/commit_stage.sv
`timescale 1ns/10ps

module commit_stage (
    input  logic                                          clk,
    input  logic                                          reset,
    input  core_pkg::result_group_t                       exec_results,
    input  logic                                          exec_valid,
    output logic                                          exec_ready,
    output core_pkg::result_group_t                       out_results,
    output logic                                          out_valid,
    input  logic                                          out_ready,
    output core_pkg::result_t [core_pkg::num_lanes-1:0]  commits
);
    import core_pkg::*;

    result_group_t res_q;
    logic          full_q;
    logic          fire;

    assign fire        = out_valid && out_ready;
    assign out_valid   = full_q;
    assign out_results = res_q;
    assign exec_ready  = !full_q || out_ready;

    // Register file sees a write only on the output transfer
    for (genvar l = 0; l < num_lanes; l++) begin : g_commit
        assign commits[l].valid = res_q[l].valid && fire;
        assign commits[l].rd    = res_q[l].rd;
        assign commits[l].value = res_q[l].value;
    end

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            full_q <= 1'b0;
            res_q  <= '0;
        end else if (exec_ready) begin
            full_q <= exec_valid;
            if (exec_valid) begin
                res_q <= exec_results;
            end
        end
    end

    hold_while_stalled: assert property (@(posedge clk) disable iff (!reset)
        out_valid && !out_ready |=> out_valid && $stable(out_results));

endmodule

// File: source/triple_issue_core.sv
`timescale 1ns/10ps

module triple_issue_core (
    input  logic                    clk,
    input  logic                    reset,
    input  core_pkg::bundle_t       in_bundle,
    input  logic                    in_valid,
    output logic                    in_ready,
    output core_pkg::result_group_t out_results,
    output logic                    out_valid,
    input  logic                    out_ready
);
    import core_pkg::*;

    // =========================================================================
    // Stage interconnect
    // =========================================================================

    group_t                           issue_group;
    logic                             issue_valid;
    logic                             issue_ready;
    result_group_t                    exec_results;
    logic                             exec_valid;
    logic                             exec_ready;
    reg_addr_t [num_read_ports-1:0]   read_addr;
    word_t     [num_read_ports-1:0]   read_data;
    result_t   [num_lanes-1:0]        commits;

    issue_decoder i_issue_decoder (
        .clk         (clk),
        .reset       (reset),
        .in_bundle   (in_bundle),
        .in_valid    (in_valid),
        .in_ready    (in_ready),
        .issue_group (issue_group),
        .issue_valid (issue_valid),
        .issue_ready (issue_ready)
    );

    execute_stage i_execute_stage (
        .clk          (clk),
        .reset        (reset),
        .issue_group  (issue_group),
        .issue_valid  (issue_valid),
        .issue_ready  (issue_ready),
        .read_addr    (read_addr),
        .read_data    (read_data),
        .exec_results (exec_results),
        .exec_valid   (exec_valid),
        .exec_ready   (exec_ready)
    );

    commit_stage i_commit_stage (
        .clk          (clk),
        .reset        (reset),
        .exec_results (exec_results),
        .exec_valid   (exec_valid),
        .exec_ready   (exec_ready),
        .out_results  (out_results),
        .out_valid    (out_valid),
        .out_ready    (out_ready),
        .commits      (commits)
    );

    multi_port_register_file i_multi_port_register_file (
        .clk       (clk),
        .reset     (reset),
        .read_addr (read_addr),
        .read_data (read_data),
        .commits   (commits)
    );

endmodule

// File: testbench/core_tb.sv
`timescale 1ns/10ps

module core_tb;
    import core_pkg::*;

    // Watchdog allows four times the rough cycle count of all tests
    localparam int reset_cycles   = 10;
    localparam int test_cycles    = 20 + 10 + 20 + 15 + 250 + 30;
    localparam int watchdog_limit = 4 * (reset_cycles + test_cycles);
    localparam int clk_period     = 20;

    logic          clk;
    logic          reset;
    bundle_t       in_bundle;
    logic          in_valid;
    logic          in_ready;
    result_group_t out_results;
    logic          out_valid;
    logic          out_ready;

    word_t         model_regs [num_regs];
    result_group_t expected_q [$];
    result_group_t held_results;
    logic          was_stalled;
    logic          stall_mode;
    logic [2:0]    span_left;
    logic [15:0]   data_lfsr;
    logic [15:0]   stall_lfsr;
    time           accept_time;
    int            checks;
    int            errors;

    triple_issue_core i_triple_issue_core (
        .clk         (clk),
        .reset       (reset),
        .in_bundle   (in_bundle),
        .in_valid    (in_valid),
        .in_ready    (in_ready),
        .out_results (out_results),
        .out_valid   (out_valid),
        .out_ready   (out_ready)
    );

    always #(clk_period / 2) clk = ~clk;

    // ========================================================================
    // Random numbers and stimulus helpers
    // ========================================================================

    function automatic logic [15:0] lfsr_step(logic [15:0] state);
        return state[0] ? ((state >> 1) ^ 16'hB400) : (state >> 1);
    endfunction

    // One LFSR step per bit taken
    function automatic int data_bits(int n);
        int v;
        v = 0;
        for (int i = 0; i < n; i++) begin
            v         = (v << 1) | int'(data_lfsr[0]);
            data_lfsr = lfsr_step(data_lfsr);
        end
        return v;
    endfunction

    function automatic instr_t make_instr(alu_op_t op, int rd, int rs1, int rs2, int imm);
        instr_t ins;
        ins.opcode = op;
        ins.rd     = rd[reg_addr_width-1:0];
        ins.rs1    = rs1[reg_addr_width-1:0];
        ins.rs2    = rs2[reg_addr_width-1:0];
        ins.imm    = imm[imm_width-1:0];
        return ins;
    endfunction

    // Operand register from the x1..x12 pool
    function automatic int pool_reg();
        return 1 + data_bits(4) % 12;
    endfunction

    // ========================================================================
    // Reference model
    // ========================================================================

    // Walks the bundle in program order and closes a group whenever a slot
    // touches a register already written inside the current group
    task automatic model_bundle(bundle_t b);
        logic [num_regs-1:0] written;
        result_group_t       grp;
        instr_t              ins;
        alu_op_t             op;
        reg_addr_t           rd;
        logic                use_b;
        word_t               a;
        word_t               bv;
        word_t               imm_val;
        word_t               val;
        written = '0;
        grp     = '0;
        for (int s = 0; s < num_lanes; s++) begin
            if (b.valid[s]) begin
                ins   = b.slot[s];
                op    = ins.opcode[opcode_width-1] ? op_add : alu_op_t'(ins.opcode);
                rd    = ins.opcode[opcode_width-1] ? '0 : ins.rd;
                use_b = (op != op_addi);
                if (written[ins.rs1] || (use_b && written[ins.rs2]) || written[rd]) begin
                    expected_q.push_back(grp);
                    grp     = '0;
                    written = '0;
                end
                a       = model_regs[ins.rs1];
                bv      = model_regs[ins.rs2];
                imm_val = word_t'($signed(ins.imm));
                case (op)
                    op_sub:  val = a - bv;
                    op_and:  val = a & bv;
                    op_or:   val = a | bv;
                    op_xor:  val = a ^ bv;
                    op_sll:  val = a << bv[4:0];
                    op_srl:  val = a >> bv[4:0];
                    op_addi: val = a + imm_val;
                    default: val = a + bv;
                endcase
                grp[s].valid = 1'b1;
                grp[s].rd    = rd;
                grp[s].value = val;
                if (rd != '0) begin
                    written[rd]    = 1'b1;
                    model_regs[rd] = val;
                end
            end
        end
        if (grp[0].valid || grp[1].valid || grp[2].valid) begin
            expected_q.push_back(grp);
        end
    endtask

    // ========================================================================
    // Checks
    // ========================================================================

    task automatic check_results(result_group_t got, result_group_t exp, string what);
        checks++;
        for (int l = 0; l < num_lanes; l++) begin
            if (got[l].valid != exp[l].valid ||
                (exp[l].valid && (got[l].rd != exp[l].rd || got[l].value != exp[l].value))) begin
                errors++;
                $display("Fail at %0t: %s lane %0d got valid %b rd %0d value %h, ",
                         "expected valid %b rd %0d value %h",
                         $time, what, l, got[l].valid, got[l].rd, got[l].value,
                         exp[l].valid, exp[l].rd, exp[l].value);
            end
        end
    endtask

    task automatic verify_latency(int got, int exp, string what);
        checks++;
        if (got != exp) begin
            errors++;
            $display("Fail at %0t: %s took %0d cycles, expected %0d", $time, what, got, exp);
        end
    endtask

    // Output monitor pops one expected group per transfer
    always @(posedge clk) begin
        if (reset && out_valid) begin
            if (was_stalled) begin
                check_results(out_results, held_results, "stalled group");
            end
            if (out_ready) begin
                if (expected_q.size() == 0) begin
                    errors++;
                    $display("Output transfer at %0t with no group left to expect", $time);
                end else begin
                    check_results(out_results, expected_q.pop_front(), "output group");
                end
                was_stalled = 1'b0;
            end else begin
                was_stalled  = 1'b1;
                held_results = out_results;
            end
        end else if (reset && was_stalled) begin
            errors++;
            $display("out_valid fell at %0t while the output was stalled", $time);
            was_stalled = 1'b0;
        end
    end

    // Output back-pressure in random spans of up to 8 cycles
    always @(negedge clk) begin
        if (!stall_mode) begin
            out_ready = 1'b1;
            span_left = '0;
        end else if (span_left == '0) begin
            out_ready  = stall_lfsr[0];
            stall_lfsr = lfsr_step(stall_lfsr);
            for (int i = 0; i < 3; i++) begin
                span_left  = {span_left[1:0], stall_lfsr[0]};
                stall_lfsr = lfsr_step(stall_lfsr);
            end
        end else begin
            span_left = span_left - 3'd1;
        end
    end

    // ========================================================================
    // Drivers
    // ========================================================================

    task automatic send_bundle(bundle_t b);
        @(negedge clk);
        in_bundle = b;
        in_valid  = 1'b1;
        model_bundle(b);
        do @(posedge clk); while (!in_ready);
        accept_time = $time;
    endtask

    task automatic release_input();
        @(negedge clk);
        in_valid = 1'b0;
    endtask

    task automatic wait_drained();
        release_input();
        while (expected_q.size() != 0) @(posedge clk);
        repeat (2) @(posedge clk);
    endtask

    // ========================================================================
    // Tests
    // ========================================================================

    task automatic independent_bundles();
        bundle_t b;
        b       = '0;
        b.valid = '1;
        // Fill x1..x12 with random immediates
        for (int k = 0; k < 4; k++) begin
            for (int s = 0; s < num_lanes; s++) begin
                b.slot[s] = make_instr(op_addi, 1 + 3 * k + s, 0, 0, data_bits(10));
            end
            send_bundle(b);
        end
        for (int k = 0; k < 8; k++) begin
            for (int s = 0; s < num_lanes; s++) begin
                b.slot[s] = make_instr(alu_op_t'((k + s) % 8), 13 + 3 * (k % 6) + s,
                                       pool_reg(), pool_reg(), data_bits(10));
            end
            send_bundle(b);
        end
        wait_drained();
    endtask

    task automatic x0_handling();
        bundle_t b;
        b         = '0;
        b.valid   = '1;
        b.slot[0] = make_instr(op_addi, 0, 5, 0, 7);
        b.slot[1] = make_instr(op_add, 31, 0, 0, 0);
        b.slot[2] = make_instr(op_or, 32, 0, 3, 0);
        send_bundle(b);
        b.valid   = 3'b011;
        b.slot[0] = make_instr(op_sub, 33, 3, 0, 0);
        b.slot[1] = make_instr(op_xor, 34, 0, 0, 0);
        send_bundle(b);
        wait_drained();
    endtask

    task automatic hazard_split();
        bundle_t b;
        b         = '0;
        b.valid   = '1;
        // Read after write, then a repeated rd
        b.slot[0] = make_instr(op_add, 40, 1, 2, 0);
        b.slot[1] = make_instr(op_sub, 41, 40, 3, 0);
        b.slot[2] = make_instr(op_xor, 41, 4, 5, 0);
        send_bundle(b);
        b.slot[0] = make_instr(op_or, 42, 6, 7, 0);
        b.slot[1] = make_instr(op_and, 43, 8, 9, 0);
        b.slot[2] = make_instr(op_srl, 44, 42, 10, 0);
        send_bundle(b);
        // Middle slot invalid
        b.valid   = 3'b101;
        b.slot[0] = make_instr(op_addi, 45, 1, 0, 300);
        b.slot[1] = make_instr(op_add, 45, 45, 45, 0);
        b.slot[2] = make_instr(op_sll, 46, 45, 2, 0);
        send_bundle(b);
        // addi ignores its rs2 field
        b.valid   = '1;
        b.slot[0] = make_instr(op_addi, 47, 3, 0, -5);
        b.slot[1] = make_instr(op_addi, 48, 9, 47, 12);
        b.slot[2] = make_instr(op_add, 49, 47, 1, 0);
        send_bundle(b);
        wait_drained();
    endtask

    task automatic forwarding_chain();
        bundle_t b;
        b       = '0;
        b.valid = '1;
        // Each bundle reads the registers the previous bundle wrote
        for (int k = 0; k < 6; k++) begin
            for (int s = 0; s < num_lanes; s++) begin
                b.slot[s] = make_instr(alu_op_t'((3 * k + s) % 8), 50 + 3 * (k % 2) + s,
                                       50 + 3 * ((k + 1) % 2) + s,
                                       50 + 3 * ((k + 1) % 2) + (s + 1) % 3, data_bits(10));
            end
            send_bundle(b);
        end
        wait_drained();
    endtask

    task automatic random_backpressure();
        bundle_t b;
        int      mask_bits;
        b          = '0;
        stall_mode = 1'b1;
        for (int k = 0; k < 16; k++) begin
            mask_bits = data_bits(num_lanes);
            b.valid   = mask_bits[num_lanes-1:0];
            if (b.valid == '0) begin
                b.valid = '1;
            end
            for (int s = 0; s < num_lanes; s++) begin
                b.slot[s] = make_instr(alu_op_t'(data_bits(3)), data_bits(6), data_bits(6),
                                       data_bits(6), data_bits(10));
            end
            send_bundle(b);
        end
        wait_drained();
        stall_mode = 1'b0;
        repeat (2) @(posedge clk);
    endtask

    task automatic issue_latency();
        bundle_t b;
        time     fire_time;
        b       = '0;
        b.valid = '1;
        for (int k = 0; k < 4; k++) begin
            for (int s = 0; s < num_lanes; s++) begin
                b.slot[s] = make_instr(op_addi, 56 + s, pool_reg(), 0, data_bits(10));
            end
            send_bundle(b);
            release_input();
            do @(posedge clk); while (!(out_valid && out_ready));
            fire_time = $time;
            verify_latency(int'((fire_time - accept_time) / clk_period), 2, "issue to output");
        end
        wait_drained();
    endtask

    // ========================================================================
    // Main sequence and watchdog
    // ========================================================================

    initial begin
        clk          = 1'b0;
        reset        = 1'b0;
        in_bundle    = '0;
        in_valid     = 1'b0;
        out_ready    = 1'b1;
        stall_mode   = 1'b0;
        span_left    = '0;
        was_stalled  = 1'b0;
        held_results = '0;
        data_lfsr    = 16'd51793;
        stall_lfsr   = 16'd51793;
        accept_time  = 0;
        checks       = 0;
        errors       = 0;
        for (int r = 0; r < num_regs; r++) begin
            model_regs[r] = '0;
        end
        repeat (5) @(posedge clk);
        @(negedge clk);
        reset = 1'b1;
        independent_bundles();
        x0_handling();
        hazard_split();
        forwarding_chain();
        random_backpressure();
        issue_latency();
        if (expected_q.size() != 0) begin
            errors++;
            $display("%0d expected groups never reached the output", expected_q.size());
        end
        $display("Checks run: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

    initial begin
        repeat (watchdog_limit) @(posedge clk);
        $display("The tests did not finish within %0d cycles, the DUT seems to hang",
                 watchdog_limit);
        $display("Checks run: %0d, errors: %0d", checks, errors);
        $display("Errors found");
        $finish;
    end

endmodule

// File: files.f
source/core_pkg.sv
source/lane_alu.sv
source/issue_decoder.sv
source/multi_port_register_file.sv
source/execute_stage.sv
source/commit_stage.sv
source/triple_issue_core.sv
testbench/core_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f files.f --top-module core_tb
./obj_dir/Vcore_tb > sim.log
cat sim.log

if grep -q "Errors found" sim.log; then
    exit 1
fi
exit 0
